/* all.f */
+incdir+design
design/valu_pkg.sv
design/valu_decode.sv
design/valu_lane_alu.sv
design/valu_red_fsm.sv
design/valu_vid_counter.sv
design/valu_top.sv
verification/valu_clk_gen.sv
verification/valu_checker.sv
verification/valu_tb.sv

/* Bender.yml */
package:
  name: valu

sources:
  - include_dirs:
      - design
    files:
      - design/valu_pkg.sv
      - design/valu_decode.sv
      - design/valu_lane_alu.sv
      - design/valu_red_fsm.sv
      - design/valu_vid_counter.sv
      - design/valu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/valu_clk_gen.sv
      - verification/valu_checker.sv
      - verification/valu_tb.sv

/* verification/valu_tb.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_tb import valu_pkg::*; ();

    logic        clk;
    logic        rst;
    valu_req_t   req;
    valu_resp_t  resp;
    logic [31:0] lfsr = 32'h4277_9da1;
    valu_resp_t  exp_q[$];
    logic        red_busy;
    int          red_op;
    int          red_w;
    logic [63:0] red_acc;
    logic [7:0]  vid_cnt;
    int          elem_codes[9] = '{0, 2, 4, 5, 6, 7, 9, 10, 11};

    valu_clk_gen clk_gen0 (.clk(clk), .rst(rst));

    valu_top dut0 (.clk(clk), .rst(rst), .req(req), .resp(resp));

    function automatic logic [63:0] rnd_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // Taps 32, 22, 2, 1
        end
        return v;
    endfunction

    function automatic logic [63:0] width_mask(int w);
        return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
    endfunction

    // One lane of width w with operands already masked to the lane
    function automatic logic [63:0] calc(int code, int w, logic [63:0] a, logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = $signed(a << (64 - w)); // Sign bit moved to bit 63
        sb = $signed(b << (64 - w));
        case (code)
            0:  return (a + b) & width_mask(w);
            2:  return (a - b) & width_mask(w);
            4:  return (a < b) ? a : b;
            5:  return (sa < sb) ? a : b;
            6:  return (a < b) ? b : a;
            7:  return (sa < sb) ? b : a;
            9:  return a & b;
            10: return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic predict(valu_req_t r, output valu_resp_t e);
        int          w;
        int          n;
        int          idx;
        logic [63:0] out;
        e = '0;
        w = 8 << r.sew;
        n = 64 / w;
        out = '0;
        if (!r.valid) return;
        if (r.op_mnr == 0 && r.func_id inside {0, 2, 4, 5, 6, 7, 9, 10, 11}) begin
            for (int k = 0; k < n; k++) begin
                out |= calc(r.func_id, w, (r.data0.d64 >> (k * w)) & width_mask(w),
                            (r.data1.d64 >> (k * w)) & width_mask(w)) << (k * w);
            end
            e.valid = 1'b1;
        end else if (r.op_mnr == `VALU_MNR_RED && r.func_id <= 7) begin
            if (r.start) begin
                red_busy = 1'b1;
                red_op   = (r.func_id inside {1, 2, 3}) ? r.func_id + 8 : r.func_id;
                red_w    = w;
                red_acc  = r.data1.d64 & width_mask(w);
            end
            if (!red_busy) return; // Stray beat
            for (int k = 0; k < 64 / red_w; k++) begin
                if (r.be[k * red_w / 8]) begin
                    red_acc = calc(red_op, red_w, red_acc,
                                   (r.data0.d64 >> (k * red_w)) & width_mask(red_w));
                end
            end
            if (!r.last) return;
            red_busy = 1'b0;
            e.valid  = 1'b1;
            out      = red_acc;
            r.be     = 8'((16'd1 << (red_w / 8)) - 16'd1);
        end else if (r.op_mnr == `VALU_MNR_RED && r.func_id == `VALU_FUNC_VID) begin
            idx = r.start ? 0 : int'(vid_cnt);
            for (int k = 0; k < n; k++) out |= ((idx * n + k) & width_mask(w)) << (k * w);
            vid_cnt = r.last ? 8'd0 : 8'(idx + 1);
            e.valid = 1'b1;
        end
        e.data.d64 = out;
        e.addr     = r.addr;
        e.be       = r.be;
        e.vl       = r.vl;
    endtask

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic valu_req_t rand_req();
        valu_req_t r;
        r.valid     = 1'b1;
        r.op_mnr    = 3'(rnd_bits(3));
        r.func_id   = 6'(rnd_bits(6));
        r.sew       = sew_e'(2'(rnd_bits(2)));
        r.data0.d64 = rnd_bits(64);
        r.data1.d64 = rnd_bits(64);
        r.addr      = 32'(rnd_bits(32));
        r.be        = 8'(rnd_bits(8));
        r.vl        = 8'(rnd_bits(8));
        r.start     = 1'(rnd_bits(1));
        r.last      = 1'(rnd_bits(1));
        return r;
    endfunction

    // Invalid, unknown class or undecoded function code
    function automatic valu_req_t junk_req();
        valu_req_t r;
        r = rand_req();
        case (rnd_bits(2))
            0: r.valid = 1'b0;
            1: r.op_mnr = 3'(3 + rnd_bits(2));
            2: begin
                r.op_mnr  = 3'd0;
                r.func_id = 6'(12 + rnd_bits(5));
            end
            default: begin
                r.op_mnr  = 3'(`VALU_MNR_RED);
                r.func_id = 6'(8 + rnd_bits(3));
            end
        endcase
        return r;
    endfunction

    function automatic valu_req_t elem_req(logic signs_differ);
        valu_req_t r;
        r = rand_req();
        r.op_mnr  = 3'd0;
        r.func_id = 6'(elem_codes[rnd_bits(4) % 9]);
        if (signs_differ) begin
            r.func_id   = 6'(4 + rnd_bits(2));
            r.data0.d64 = 64'h8181_8181_8181_8181; // Top bit set in every lane
            r.data1.d64 = 64'h7e7e_7e7e_7e7e_7e7e;
        end
        return r;
    endfunction

    task automatic run_cycle(valu_req_t nreq);
        valu_resp_t e;
        valu_resp_t got;
        @(posedge clk);
        req <= nreq;
        predict(nreq, e);
        exp_q.push_back(e);
        @(negedge clk);
        got = resp;
        e   = exp_q.pop_front();
        assert (got.valid == e.valid && (!e.valid || got == e)) else
            stop_run($sformatf("ERROR at %0t: expected %0b %h be=%h a=%h vl=%h, got %0b %h %h %h %h",
                               $time, e.valid, e.data.d64, e.be, e.addr, e.vl,
                               got.valid, got.data.d64, got.be, got.addr, got.vl));
        assert (dut0.u_checker.fail_cnt == 0) else
            stop_run("A protocol assertion on the DUT response fired");
    endtask

    // Reductions and vid share the beat framing and junk may slip in between
    task automatic run_seq(int func, int len);
        sew_e      s;
        valu_req_t r;
        s = sew_e'(2'(rnd_bits(2)));
        for (int b = 0; b < len; b++) begin
            r         = rand_req();
            r.op_mnr  = 3'(`VALU_MNR_RED);
            r.func_id = 6'(func);
            r.sew     = s;
            r.start   = (b == 0) || (rnd_bits(3) == 0);
            r.last    = (b == len - 1);
            run_cycle(r);
            if (rnd_bits(2) == 0) run_cycle(junk_req());
        end
    endtask

    initial begin
        int kind;
        int wait_cnt;
        req      = '0;
        red_busy = 1'b0;
        vid_cnt  = '0;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
            assert (wait_cnt < 20) else stop_run("Timed out waiting for reset release");
        end while (rst);
        exp_q.push_back('0);
        exp_q.push_back('0);
        repeat (4) run_cycle(junk_req());
        repeat (400) begin
            kind = int'(rnd_bits(3));
            if (kind == 2) run_seq(int'(rnd_bits(3)), int'(rnd_bits(3) % 5) + 1);
            else if (kind == 3) run_seq(`VALU_FUNC_VID, int'(rnd_bits(2)) + 1);
            else if (kind == 4) run_cycle(junk_req());
            else run_cycle(elem_req(kind == 5));
        end
        wait_cnt = 0;
        while (exp_q[0].valid || exp_q[1].valid) begin
            run_cycle('0);
            wait_cnt++;
            assert (wait_cnt < 10) else stop_run("Timed out draining expected responses");
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

/* verification/valu_checker.sv */
`timescale 1ns/1ps

module valu_checker import valu_pkg::*; (
    input logic       clk,
    input logic       rst,
    input valu_req_t  req,
    input valu_resp_t resp,
    input logic       alu_go,
    input logic       red_go,
    input logic       vid_go
);

    int unsigned fail_cnt = 0;

    a_reset_clears: assert property (@(posedge clk) rst |=> !resp.valid)
        else begin
            $error("resp.valid high in the cycle after reset");
            fail_cnt++;
        end

    a_elem_latency: assert property (@(posedge clk) disable iff (rst) alu_go |-> ##2 resp.valid)
        else begin
            $error("Element request not answered two cycles later");
            fail_cnt++;
        end

    // Only element, vid or a closing reduction beat can raise a response
    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        $rose(resp.valid) |-> $past(alu_go || vid_go || (red_go && req.last), 2))
        else begin
            $error("resp.valid rose without a qualifying request");
            fail_cnt++;
        end

endmodule

bind valu_top valu_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .resp   (resp),
    .alu_go (alu_go),
    .red_go (red_go),
    .vid_go (vid_go)
);

/* verification/valu_clk_gen.sv */
`timescale 1ns/1ps

module valu_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* design/valu_top.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_top import valu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  valu_req_t  req,
    output valu_resp_t resp
);

    localparam int RESP_W = 1 + `VALU_DATA_W + `VALU_ADDR_W + `VALU_BE_W + `VALU_VL_W;

    logic              alu_go;
    logic              red_go;
    logic              vid_go;
    alu_op_e           op;
    valu_resp_t        alu_resp;
    valu_resp_t        red_resp;
    valu_resp_t        vid_resp;
    logic [RESP_W-1:0] merged;
    valu_resp_t        merged_s;
    logic              valid_q;
    valu_resp_t        pay_q;

    valu_decode u_decode (
        .req    (req),
        .alu_go (alu_go),
        .red_go (red_go),
        .vid_go (vid_go),
        .op     (op)
    );

    valu_lane_alu u_lane_alu (
        .clk  (clk),
        .rst  (rst),
        .go   (alu_go),
        .op   (op),
        .req  (req),
        .resp (alu_resp)
    );

    valu_red_fsm u_red_fsm (
        .clk  (clk),
        .rst  (rst),
        .go   (red_go),
        .op   (op),
        .req  (req),
        .resp (red_resp)
    );

    valu_vid_counter u_vid_counter (
        .clk  (clk),
        .rst  (rst),
        .go   (vid_go),
        .req  (req),
        .resp (vid_resp)
    );

    // At most one unit fires per cycle and idle units output zero
    assign merged   = alu_resp | red_resp | vid_resp;
    assign merged_s = valu_resp_t'(merged);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= merged_s.valid;
        end
    end

    always_ff @(posedge clk) begin
        pay_q <= merged_s;
    end

    always_comb begin
        resp       = pay_q;
        resp.valid = valid_q;
    end

endmodule

/* design/valu_vid_counter.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_vid_counter import valu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      go,
    input  valu_req_t req,
    output valu_resp_t resp
);

    logic [`VALU_VL_W-1:0] cnt_q;
    logic [`VALU_VL_W-1:0] idx;
    lane_word_u            lanes;
    logic                  valid_q;
    valu_resp_t            pay_q;

    assign idx = req.start ? '0 : cnt_q;

    // Element index is beat index times elements per beat plus lane
    always_comb begin
        case (req.sew)
            sew8:  for (int k = 0; k < 8; k++) lanes.b8[k] = 8'(idx * 8 + k);
            sew16: for (int k = 0; k < 4; k++) lanes.h16[k] = 16'(idx * 4 + k);
            sew32: for (int k = 0; k < 2; k++) lanes.w32[k] = 32'(idx * 2 + k);
            default: lanes.d64 = `VALU_DATA_W'(idx);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (go) cnt_q <= req.last ? '0 : idx + 1'b1;
            valid_q <= go;
        end
    end

    always_ff @(posedge clk) begin
        pay_q <= '0;
        if (go) begin
            pay_q.data <= lanes;
            pay_q.addr <= req.addr;
            pay_q.be   <= req.be;
            pay_q.vl   <= req.vl;
        end
    end

    always_comb begin
        resp       = pay_q;
        resp.valid = valid_q;
    end

endmodule

/* design/valu_red_fsm.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_red_fsm import valu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      go,
    input  alu_op_e   op,
    input  valu_req_t req,
    output valu_resp_t resp
);

    logic                    busy_q; // 0 idle, 1 accumulating
    logic [`VALU_DATA_W-1:0] acc_q;
    alu_op_e                 op_q;
    sew_e                    sew_q;
    logic                    take;
    alu_op_e                 cur_op;
    sew_e                    cur_sew;
    logic [`VALU_DATA_W-1:0] lane_mask;
    logic [`VALU_DATA_W-1:0] base;
    logic [`VALU_DATA_W-1:0] fold;
    logic [`VALU_BE_W-1:0]   be0;
    logic                    valid_q;
    valu_resp_t              pay_q;

    assign take    = go & (req.start | busy_q); // Stray beats while idle are dropped
    assign cur_op  = req.start ? op : op_q;
    assign cur_sew = req.start ? req.sew : sew_q;

    assign lane_mask = {`VALU_DATA_W{1'b1}} >> (7'd64 - (7'd8 << cur_sew));
    assign base      = req.start ? (req.data1.d64 & lane_mask) : acc_q;
    assign be0       = `VALU_BE_W'((9'd1 << (4'd1 << cur_sew)) - 9'd1);

    // Fold every element whose lowest byte is enabled, lowest element first
    always_comb begin
        fold = base;
        case (cur_sew)
            sew8: begin
                for (int k = 0; k < 8; k++) begin
                    if (req.be[k]) fold = lane_fold(cur_op, cur_sew, fold,
                                                    `VALU_DATA_W'(req.data0.b8[k]));
                end
            end
            sew16: begin
                for (int k = 0; k < 4; k++) begin
                    if (req.be[2*k]) fold = lane_fold(cur_op, cur_sew, fold,
                                                      `VALU_DATA_W'(req.data0.h16[k]));
                end
            end
            sew32: begin
                for (int k = 0; k < 2; k++) begin
                    if (req.be[4*k]) fold = lane_fold(cur_op, cur_sew, fold,
                                                      `VALU_DATA_W'(req.data0.w32[k]));
                end
            end
            default: begin
                if (req.be[0]) fold = lane_fold(cur_op, cur_sew, fold, req.data0.d64);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (take) busy_q <= ~req.last;
            valid_q <= take & req.last;
        end
    end

    always_ff @(posedge clk) begin
        if (take) acc_q <= fold;
        if (go && req.start) begin
            op_q  <= op;
            sew_q <= req.sew;
        end
    end

    always_ff @(posedge clk) begin
        pay_q <= '0;
        if (take && req.last) begin
            pay_q.data <= fold; // Upper elements are already zero
            pay_q.addr <= req.addr;
            pay_q.be   <= be0;
            pay_q.vl   <= req.vl;
        end
    end

    always_comb begin
        resp       = pay_q;
        resp.valid = valid_q;
    end

endmodule

/* design/valu_lane_alu.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_lane_alu import valu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      go,
    input  alu_op_e   op,
    input  valu_req_t req,
    output valu_resp_t resp
);

    lane_word_u res;
    logic       valid_q;
    valu_resp_t pay_q;

    // Each SEW view runs its own set of lanes through the shared fold
    always_comb begin
        case (req.sew)
            sew8: begin
                for (int k = 0; k < 8; k++) begin
                    res.b8[k] = 8'(lane_fold(op, req.sew,
                                             `VALU_DATA_W'(req.data0.b8[k]),
                                             `VALU_DATA_W'(req.data1.b8[k])));
                end
            end
            sew16: begin
                for (int k = 0; k < 4; k++) begin
                    res.h16[k] = 16'(lane_fold(op, req.sew,
                                               `VALU_DATA_W'(req.data0.h16[k]),
                                               `VALU_DATA_W'(req.data1.h16[k])));
                end
            end
            sew32: begin
                for (int k = 0; k < 2; k++) begin
                    res.w32[k] = 32'(lane_fold(op, req.sew,
                                               `VALU_DATA_W'(req.data0.w32[k]),
                                               `VALU_DATA_W'(req.data1.w32[k])));
                end
            end
            default: begin
                res.d64 = lane_fold(op, req.sew, req.data0.d64, req.data1.d64);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= go;
        end
    end

    // Idle cycles load zero so the top can OR the unit outputs
    always_ff @(posedge clk) begin
        pay_q <= '0;
        if (go) begin
            pay_q.data <= res;
            pay_q.addr <= req.addr;
            pay_q.be   <= req.be; // be does not mask element results
            pay_q.vl   <= req.vl;
        end
    end

    always_comb begin
        resp       = pay_q;
        resp.valid = valid_q;
    end

endmodule

/* design/valu_decode.sv */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_decode import valu_pkg::*; (
    input  valu_req_t req,
    output logic      alu_go,
    output logic      red_go,
    output logic      vid_go,
    output alu_op_e   op
);

    logic elem_hit;
    logic red_hit;
    logic vid_hit;
    logic is_elem;
    logic is_red;

    assign is_elem = (req.op_mnr == 3'd0);
    assign is_red  = (req.op_mnr == 3'(`VALU_MNR_RED));

    always_comb begin
        op       = op_add;
        elem_hit = 1'b0;
        red_hit  = 1'b0;
        vid_hit  = 1'b0;
        case (req.func_id)
            `VALU_FUNC_W'(0): begin
                op       = op_add;
                elem_hit = is_elem;
                red_hit  = is_red;
            end
            `VALU_FUNC_W'(1): begin
                op      = op_and; // Reduction only
                red_hit = is_red;
            end
            `VALU_FUNC_W'(2): begin
                op       = is_red ? op_or : op_sub;
                elem_hit = is_elem;
                red_hit  = is_red;
            end
            `VALU_FUNC_W'(3): begin
                op      = op_xor;
                red_hit = is_red;
            end
            `VALU_FUNC_W'(4), `VALU_FUNC_W'(5), `VALU_FUNC_W'(6), `VALU_FUNC_W'(7): begin
                op       = alu_op_e'(4'(op_minu) + 4'(req.func_id[1:0])); // Same order as codes 4..7
                elem_hit = is_elem;
                red_hit  = is_red;
            end
            `VALU_FUNC_W'(9): begin
                op       = op_and;
                elem_hit = is_elem;
            end
            `VALU_FUNC_W'(10): begin
                op       = op_or;
                elem_hit = is_elem;
            end
            `VALU_FUNC_W'(11): begin
                op       = op_xor;
                elem_hit = is_elem;
            end
            `VALU_FUNC_W'(`VALU_FUNC_VID): vid_hit = is_red;
            default: ;
        endcase
    end

    assign alu_go = req.valid & elem_hit;
    assign red_go = req.valid & red_hit;
    assign vid_go = req.valid & vid_hit;

endmodule

/* design/valu_pkg.sv */
package valu_pkg;

    typedef enum logic [1:0] {
        sew8,
        sew16,
        sew32,
        sew64
    } sew_e;

    // One beat read as lanes of the current element width
    typedef union packed {
        logic [7:0][7:0]  b8;
        logic [3:0][15:0] h16;
        logic [1:0][31:0] w32;
        logic [63:0]      d64;
    } lane_word_u;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_minu,
        op_min,
        op_maxu,
        op_max,
        op_and,
        op_or,
        op_xor
    } alu_op_e;

    typedef struct packed {
        logic       valid;
        logic [2:0] op_mnr;
        logic [5:0] func_id;
        sew_e       sew;
        lane_word_u data0;
        lane_word_u data1;
        logic [31:0] addr;
        logic [7:0] be;
        logic [7:0] vl;
        logic       start;
        logic       last;
    } valu_req_t;

    typedef struct packed {
        logic        valid;
        lane_word_u  data;
        logic [31:0] addr;
        logic [7:0]  be;
        logic [7:0]  vl;
    } valu_resp_t;

    // Operands are zero-extended lane values, result is masked to the lane
    function automatic logic [63:0] lane_fold(alu_op_e op, sew_e sew,
                                              logic [63:0] a, logic [63:0] b);
        logic [63:0] mask;
        logic [63:0] msb;
        logic        lt_u;
        logic        lt_s;
        mask = {64{1'b1}} >> (7'd64 - (7'd8 << sew));
        msb  = mask ^ (mask >> 1);
        lt_u = a < b;
        lt_s = (a ^ msb) < (b ^ msb); // Flipping the sign bit orders signed values
        case (op)
            op_add:  lane_fold = (a + b) & mask;
            op_sub:  lane_fold = (a - b) & mask;
            op_minu: lane_fold = lt_u ? a : b;
            op_min:  lane_fold = lt_s ? a : b;
            op_maxu: lane_fold = lt_u ? b : a;
            op_max:  lane_fold = lt_s ? b : a;
            op_and:  lane_fold = a & b;
            op_or:   lane_fold = a | b;
            default: lane_fold = a ^ b;
        endcase
    endfunction

endpackage

/* design/valu_settings.svh */
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// Beat geometry
`define VALU_DATA_W 64
`define VALU_BE_W 8

// Sideband fields carried with every beat
`define VALU_ADDR_W 32
`define VALU_VL_W 8

// Instruction fields
`define VALU_FUNC_W 6

// op_mnr class shared by reductions and vid
`define VALU_MNR_RED 2

// vid function code inside the reduction class
`define VALU_FUNC_VID 20

`endif
